/* Makefile */
VERILATOR ?= verilator
TOP       ?= ingress_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

/* bench/ingress_checker.sv */
////////////////////////////////////////////////////////////////////////////
// bound into stream_ingress_top and mirrors credit and FIFO occupancy
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ingress_checker #(
    parameter int queue_beats = 64,
    parameter int fifo_depth  = 16
) (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 tvalid,
    input logic                                 tready,
    input logic                                 tlast,
    input logic [ingress_pkg::length_width-1:0] tuser,
    input logic                                 cal_done,
    input logic                                 hold,
    input logic                                 write,
    input logic                                 release_beat,
    input logic                                 push,
    input logic                                 rd,
    input logic                                 empty
);

    // assertion failures so far
    int   fail_count = 0;
    int   occupancy;
    int   credit;
    logic first_beat;
    logic xfer;

    assign xfer = tvalid && tready;

    // shadow of FIFO fill, credit and packet start
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            occupancy  <= 0;
            credit     <= queue_beats;
            first_beat <= 1'b1;
        end
        else
        begin
            occupancy <= occupancy + int'(push) - int'(rd && !empty);
            credit    <= credit - int'(write) + int'(release_beat);
            if (xfer)
                first_beat <= tlast;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // intake gating
    ////////////////////////////////////////////////////////////////////////////

    // no intake while uncalibrated or flushing
    ready_gate: assert property (@(posedge clk) disable iff (reset)
        (!cal_done || hold) |-> !tready)
    else
    begin
        fail_count++;
        $error("tready high while cal_done low or packer flushing");
    end

    // first cycle out of reset stays closed
    ready_after_reset: assert property (@(posedge clk) $past(reset) |-> !tready)
    else
    begin
        fail_count++;
        $error("tready high in the cycle after reset");
    end

    ////////////////////////////////////////////////////////////////////////////
    // flush and push
    ////////////////////////////////////////////////////////////////////////////

    // flush lasts a single cycle
    hold_single: assert property (@(posedge clk) disable iff (reset) hold |=> !hold)
    else
    begin
        fail_count++;
        $error("hold stayed high for more than one cycle");
    end

    no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> (occupancy < fifo_depth))
    else
    begin
        fail_count++;
        $error("push while the entry FIFO was full");
    end

    ////////////////////////////////////////////////////////////////////////////
    // credit
    ////////////////////////////////////////////////////////////////////////////

    // first beat written exactly when credit exceeds the length
    admit_rule: assert property (@(posedge clk) disable iff (reset)
        (xfer && first_beat) |-> (write == (credit > int'(tuser))))
    else
    begin
        fail_count++;
        $error("admission decision does not follow the credit rule");
    end

endmodule

bind stream_ingress_top ingress_checker #(
    .queue_beats (queue_beats),
    .fifo_depth  (fifo_depth)
) u_checker (
    .clk          (clk),
    .reset        (reset),
    .tvalid       (tvalid),
    .tready       (tready),
    .tlast        (tlast),
    .tuser        (tuser),
    .cal_done     (cal_done),
    .hold         (beats.hold),
    .write        (beats.write),
    .release_beat (release_beat),
    .push         (push),
    .rd           (rd),
    .empty        (empty)
);

/* bench/ingress_tb.sv */
////////////////////////////////////////////////////////////////////////////
// random packets against a byte-queue model, unkept bytes driven as zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ingress_tb;

    localparam int queue_beats  = 40;
    localparam int fifo_depth   = 8;
    localparam int num_packets  = 60;
    localparam int reset_cycles = 16;
    localparam int cycle_limit  = num_packets * 6 * 4 + reset_cycles;

    logic                                 clk   = 1'b0;
    logic                                 reset = 1'b1;
    logic                                 tvalid;
    logic                                 tready;
    logic [ingress_pkg::stream_width-1:0] tdata;
    logic [ingress_pkg::stream_bytes-1:0] tkeep;
    logic                                 tlast;
    logic [ingress_pkg::length_width-1:0] tuser;
    logic                                 cal_done;
    logic                                 rd;
    logic                                 release_beat;
    logic [ingress_pkg::entry_width-1:0]  entry;
    logic                                 empty;
    logic [ingress_pkg::count_width-1:0]  beat_count;

    // model state
    logic [ingress_pkg::entry_width-1:0] expected [$];
    logic [7:0]                          pkt_bytes [$];
    int errors       = 0;
    int cycles       = 0;
    int model_credit = queue_beats;
    int owed         = 0;
    int exp_beats    = 0;
    int dropped      = 0;
    int pkt_num      = 0;
    int pkt_len      = 0;
    int beat_idx     = 0;
    int entry_idx    = 0;
    int cal_wait     = 0;
    int stall        = 0;
    bit sent         = 1'b0;
    bit pkt_admit    = 1'b0;
    bit cal_dropped  = 1'b0;
    bit stalled      = 1'b0;
    bit release_en;

    stream_ingress_top #(
        .queue_beats        (queue_beats),
        .fifo_depth         (fifo_depth),
        .almost_full_margin (3)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .tvalid       (tvalid),
        .tready       (tready),
        .tdata        (tdata),
        .tkeep        (tkeep),
        .tlast        (tlast),
        .tuser        (tuser),
        .cal_done     (cal_done),
        .rd           (rd),
        .release_beat (release_beat),
        .entry        (entry),
        .empty        (empty),
        .beat_count   (beat_count)
    );

    always #20 clk = ~clk;

    // hang guard
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("run hung: not finished after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // model helpers
    ////////////////////////////////////////////////////////////////////////////

    // contiguous keep from byte 0
    function automatic logic [3:0] keep_mask(input int bytes);
        logic [3:0] mask;
        mask = 4'b0000;
        for (int i = 0; i < bytes; i++)
            mask[i] = 1'b1;
        return mask;
    endfunction

    function automatic logic [ingress_pkg::entry_width-1:0] make_entry(
        input logic [7:0] b0,
        input logic [7:0] b1,
        input logic [7:0] b2,
        input int         phase,
        input int         count,
        input bit         last
    );
        logic [ingress_pkg::entry_width-1:0] e;
        e = '0;
        // oldest byte lowest
        e[ingress_pkg::entry_data_width-1:0] = {b2, b1, b0};
        e[ingress_pkg::count_lsb +: ingress_pkg::keep_count_width] = count[2:0];
        e[ingress_pkg::phase_lsb +: ingress_pkg::phase_width] = phase[1:0];
        e[ingress_pkg::last_pos] = last;
        return e;
    endfunction

    // three oldest bytes, zero padded on the final entry
    task automatic take_entry(input bit last, input int count);
        logic [7:0] b [3];
        for (int i = 0; i < 3; i++)
        begin
            if (pkt_bytes.size() != 0)
                b[i] = pkt_bytes.pop_front();
            else
                b[i] = 8'h00;
        end
        expected.push_back(make_entry(b[0], b[1], b[2], entry_idx % 4,
                                      last ? count : 0, last));
        entry_idx++;
    endtask

    // one beat that transfers at the coming rising edge
    task automatic record_transfer;
        exp_beats++;
        if (beat_idx == 0)
        begin
            pkt_admit = model_credit > pkt_len;
            entry_idx = 0;
            if (!pkt_admit)
                dropped++;
        end
        if (pkt_admit)
        begin
            for (int i = 0; i < 4; i++)
                pkt_bytes.push_back(tdata[8*i +: 8]);
            model_credit--;
            owed++;
            // full entries, but keep the final one for the last beat
            while (pkt_bytes.size() > 3 || (!tlast && pkt_bytes.size() == 3))
                take_entry(1'b0, 0);
            if (tlast)
                take_entry(1'b1, $countones(tkeep));
        end
    endtask

    // present beat beat_idx of packet pkt_num
    task automatic load_beat;
        int          kc;
        logic [31:0] word;
        if (beat_idx == 0)
            pkt_len = (pkt_num == 10) ? 6 : 1 + int'($urandom % 6);
        tlast = (beat_idx == pkt_len - 1);
        kc    = tlast ? 1 + int'($urandom % 4) : 4;
        word  = $urandom;
        tkeep = keep_mask(kc);
        for (int i = 0; i < 4; i++)
        begin
            if (!tkeep[i])
                word[8*i +: 8] = 8'h00;
        end
        tdata  = word;
        tuser  = pkt_len[11:0];
        tvalid = 1'b1;
    endtask

    // compare the head that pops at the next edge
    task automatic check_head;
        logic [ingress_pkg::entry_width-1:0] want;
        if (expected.size() == 0)
        begin
            errors++;
            $display("entry %h came out of the FIFO with nothing expected", entry);
        end
        else
        begin
            want = expected.pop_front();
            assert (entry == want)
            else
            begin
                errors++;
                $display("** Error entry: expected %h, got %h", want, entry);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus, one pass per falling edge
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(32'hea50));
        tvalid       = 1'b0;
        tdata        = '0;
        tkeep        = '0;
        tlast        = 1'b0;
        tuser        = '0;
        cal_done     = 1'b0;
        rd           = 1'b0;
        release_beat = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        // calibration comes up a little after reset
        repeat (2) @(negedge clk);
        cal_done = 1'b1;

        while (pkt_num < num_packets || tvalid || expected.size() != 0)
        begin
            @(negedge clk);
            assert (beat_count == 32'(exp_beats))
            else
            begin
                errors++;
                $display("** Error beat_count: expected %h, got %h", exp_beats, beat_count);
            end

            // step past the beat that went last cycle
            if (sent)
            begin
                sent = 1'b0;
                if (tlast)
                begin
                    pkt_num++;
                    beat_idx = 0;
                    tvalid   = 1'b0;
                end
                else
                begin
                    beat_idx++;
                    load_beat();
                end
            end
            if (!tvalid && pkt_num < num_packets && ($urandom % 4) != 0)
                load_beat();

            // drop calibration in the middle of packet 10
            if (pkt_num == 10 && beat_idx == 2 && !cal_dropped)
            begin
                cal_dropped = 1'b1;
                cal_done    = 1'b0;
                cal_wait    = 6;
            end
            else if (cal_wait > 0)
            begin
                cal_wait--;
                if (cal_wait == 0)
                    cal_done = 1'b1;
            end

            // reader stalls once long enough to fill the FIFO
            if (pkt_num == 36 && !stalled)
            begin
                stalled = 1'b1;
                stall   = 80;
            end
            rd = (stall == 0) && (($urandom % 8) != 0);
            if (stall > 0)
                stall--;
            if (rd && !empty)
                check_head();

            // releases withheld for a while so credit runs out
            release_en   = !(pkt_num >= 20 && pkt_num < 34);
            release_beat = release_en && owed > 0 && (($urandom % 2) == 0);

            #1;
            if (tvalid && tready)
            begin
                sent = 1'b1;
                record_transfer();
            end
            if (release_beat)
            begin
                model_credit++;
                owed--;
            end
        end

        @(negedge clk);
        rd           = 1'b0;
        release_beat = 1'b0;
        repeat (4) @(negedge clk);
        if (!empty)
        begin
            errors++;
            $display("FIFO still holds entries after the last packet");
        end
        assert (beat_count == 32'(exp_beats))
        else
        begin
            errors++;
            $display("** Error beat_count: expected %h, got %h", exp_beats, beat_count);
        end
        if (dropped == 0)
        begin
            errors++;
            $display("no packet was refused by admission");
        end

        $display("errors: testbench %0d, checker %0d", errors, DUT.u_checker.fail_count);
        if (errors == 0 && DUT.u_checker.fail_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* design/beat_if.sv */
////////////////////////////////////////////////////////////////////////////
// admitted beats toward the packer, hold back toward admission
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface beat_if;

    // one-cycle strobe per admitted beat
    logic                                      write;
    logic [ingress_pkg::stream_width-1:0]      data;
    // valid bytes of the beat, 1 to 4
    logic [ingress_pkg::keep_count_width-1:0]  keep_count;
    logic                                      last;

    // packer busy flushing, no beat may transfer
    logic                                      hold;

    modport source (output write, data, keep_count, last, input hold);

    modport sink (input write, data, keep_count, last, output hold);

endinterface

/* design/beat_packer.sv */
////////////////////////////////////////////////////////////////////////////
// packets start at phase 0, one flush cycle follows phase 2 writes and last beats
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module beat_packer (
    input  logic                                clk,
    input  logic                                reset,
    beat_if.sink                                beats,
    output logic                                push,
    output logic [ingress_pkg::entry_width-1:0] push_entry
);

    logic [ingress_pkg::phase_width-1:0]      phase;
    logic                                     last_pending;
    logic                                     flush;
    // previous beat, its upper bytes are still owed to memory
    logic [ingress_pkg::stream_width-1:0]     pend;
    logic [ingress_pkg::keep_count_width-1:0] pend_count;
    logic [ingress_pkg::stream_width-1:0]     in_data;
    logic [ingress_pkg::entry_data_width-1:0] entry_data;
    logic [ingress_pkg::entry_width-1:0]      next_entry;

    // phase 3 always flushes, any other phase flushes after a last beat
    assign flush      = (phase == 2'd3) || last_pending;
    assign beats.hold = flush;

    // no input during flush, upper lanes filled with zero
    assign in_data = flush ? '0 : beats.data;

    ////////////////////////////////////////////////////////////////////////////
    // entry assembly
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (phase)
            // bytes 0..2 of the new beat
            2'd0:    entry_data = in_data[23:0];
            // pending byte 3 then new bytes 0,1
            2'd1:    entry_data = {in_data[15:0], pend[31:24]};
            // pending bytes 2,3 then new byte 0
            2'd2:    entry_data = {in_data[7:0], pend[31:16]};
            // pending bytes 1..3
            default: entry_data = pend[31:8];
        endcase
    end

    always_comb
    begin
        next_entry = '0;
        next_entry[ingress_pkg::entry_data_width-1:0] = entry_data;
        next_entry[ingress_pkg::phase_lsb +: ingress_pkg::phase_width] = phase;
        // tag only on the final entry of a packet
        if (flush && last_pending)
        begin
            next_entry[ingress_pkg::count_lsb +: ingress_pkg::keep_count_width] = pend_count;
            next_entry[ingress_pkg::last_pos] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // phase and push registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase        <= '0;
            last_pending <= 1'b0;
            push         <= 1'b0;
        end
        else
        begin
            push <= beats.write || flush;
            if (flush)
            begin
                // back to phase 0 for the next packet or next group
                phase        <= '0;
                last_pending <= 1'b0;
            end
            else if (beats.write)
            begin
                phase        <= phase + 2'd1;
                last_pending <= beats.last;
            end
        end
    end

    // payload side
    always_ff @(posedge clk)
    begin
        if (beats.write)
        begin
            pend       <= beats.data;
            pend_count <= beats.keep_count;
        end
        push_entry <= next_entry;
    end

endmodule

/* design/entry_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// show-ahead, no overflow guard, margin must cover entries in flight
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module entry_fifo #(
    parameter int fifo_depth         = 16,
    parameter int almost_full_margin = 3
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                push,
    input  logic [ingress_pkg::entry_width-1:0] push_entry,
    input  logic                                rd,
    output logic [ingress_pkg::entry_width-1:0] entry,
    output logic                                empty,
    output logic                                almost_full
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(fifo_depth - 1);
    localparam logic [ptr_w-1:0] ptr_one   = 1;
    localparam logic [cnt_w-1:0] depth_c   = cnt_w'(fifo_depth);
    localparam logic [cnt_w-1:0] margin_c  = cnt_w'(almost_full_margin);
    localparam logic [cnt_w-1:0] cnt_one   = 1;

    logic [ingress_pkg::entry_width-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]                    wr_ptr;
    logic [ptr_w-1:0]                    rd_ptr;
    logic [cnt_w-1:0]                    count;
    logic [cnt_w-1:0]                    free_slots;
    logic                                pop;

    // head visible without a read
    assign entry       = mem[rd_ptr];
    assign empty       = (count == '0);
    assign pop         = rd && !empty;
    assign free_slots  = depth_c - count;
    assign almost_full = (free_slots <= margin_c);

    // storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_entry;
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // wrap handles depths that are not a power of two
            if (push)
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + ptr_one;
            if (pop)
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + ptr_one;
            case ({push, pop})
                2'b10:   count <= count + cnt_one;
                2'b01:   count <= count - cnt_one;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/ingress_admission.sv */
////////////////////////////////////////////////////////////////////////////
// admit decision taken on the first beat only, keep assumed contiguous from byte 0
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ingress_admission #(
    parameter int queue_beats = 64
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 tvalid,
    input  logic [ingress_pkg::stream_width-1:0] tdata,
    input  logic [ingress_pkg::stream_bytes-1:0] tkeep,
    input  logic                                 tlast,
    input  logic [ingress_pkg::length_width-1:0] tuser,
    input  logic                                 cal_done,
    input  logic                                 almost_full,
    input  logic                                 release_beat,
    output logic                                 tready,
    output logic [ingress_pkg::count_width-1:0]  beat_count,
    beat_if.source                               beats
);

    localparam int len_pad = ingress_pkg::credit_width - ingress_pkg::length_width;
    localparam logic [ingress_pkg::credit_width-1:0] credit_init =
        queue_beats[ingress_pkg::credit_width-1:0];
    localparam logic [ingress_pkg::credit_width-1:0] credit_one = 1;
    localparam logic [ingress_pkg::count_width-1:0]  count_one  = 1;

    logic                                 packet_start;
    logic                                 allow_packet;
    logic                                 xfer;
    logic                                 admit;
    logic [ingress_pkg::credit_width-1:0] credit;
    logic [ingress_pkg::credit_width-1:0] length_ext;

    // intake open only when calibrated, FIFO has room, packer not flushing
    assign tready = cal_done && !almost_full && !beats.hold;
    assign xfer   = tvalid && tready;

    // strict compare leaves one beat of slack
    assign length_ext = {{len_pad{1'b0}}, tuser};
    assign admit      = packet_start ? (credit > length_ext) : allow_packet;

    // beat goes to the packer in the same cycle
    assign beats.write = xfer && admit;
    assign beats.data  = tdata;
    assign beats.last  = tlast;

    // byte count from contiguous keep
    always_comb
    begin
        case (tkeep)
            4'b1111: beats.keep_count = 3'd4;
            4'b0111: beats.keep_count = 3'd3;
            4'b0011: beats.keep_count = 3'd2;
            default: beats.keep_count = 3'd1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // packet tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            packet_start <= 1'b1;
            allow_packet <= 1'b0;
        end
        else if (xfer)
        begin
            // next beat starts a packet after a last
            packet_start <= tlast;
            if (packet_start)
                allow_packet <= admit;
        end
    end

    // credit, write and release in one cycle cancel
    always_ff @(posedge clk)
    begin
        if (reset)
            credit <= credit_init;
        else
        begin
            case ({beats.write, release_beat})
                2'b10:   credit <= credit - credit_one;
                2'b01:   credit <= credit + credit_one;
                default: credit <= credit;
            endcase
        end
    end

    // every transferred beat counts, dropped ones too
    always_ff @(posedge clk)
    begin
        if (reset)
            beat_count <= '0;
        else if (xfer)
            beat_count <= beat_count + count_one;
    end

endmodule

/* design/ingress_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// widths shared by the ingress path, entry fields packed above the 24 data bits
////////////////////////////////////////////////////////////////////////////

package ingress_pkg;

    // input stream, one 32-bit beat with per-byte keep
    localparam int stream_bytes = 4;
    localparam int stream_width = 8 * stream_bytes;

    // memory entry data, oldest byte in the low lane
    localparam int entry_bytes      = 3;
    localparam int entry_data_width = 8 * entry_bytes;

    // tag fields above the data
    localparam int keep_count_width = 3;
    localparam int phase_width      = 2;
    localparam int entry_width      = entry_data_width + keep_count_width + phase_width + 1;

    // named bit offsets into an entry
    localparam int count_lsb = entry_data_width;
    localparam int phase_lsb = count_lsb + keep_count_width;
    localparam int last_pos  = phase_lsb + phase_width;

    // tuser length in beats, transferred-beat counter, beat credit
    localparam int length_width = 12;
    localparam int count_width  = 32;
    localparam int credit_width = 16;

endpackage

/* design/stream_ingress_top.sv */
////////////////////////////////////////////////////////////////////////////
// single clock, cal_done must stay low until reset is released
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_ingress_top #(
    parameter int queue_beats        = 64,
    parameter int fifo_depth         = 16,
    parameter int almost_full_margin = 3
) (
    input  logic                                 clk,
    input  logic                                 reset,
    // byte stream in
    input  logic                                 tvalid,
    output logic                                 tready,
    input  logic [ingress_pkg::stream_width-1:0] tdata,
    input  logic [ingress_pkg::stream_bytes-1:0] tkeep,
    input  logic                                 tlast,
    input  logic [ingress_pkg::length_width-1:0] tuser,
    input  logic                                 cal_done,
    // reader side
    input  logic                                 rd,
    input  logic                                 release_beat,
    output logic [ingress_pkg::entry_width-1:0]  entry,
    output logic                                 empty,
    output logic [ingress_pkg::count_width-1:0]  beat_count
);

    logic                                push;
    logic [ingress_pkg::entry_width-1:0] push_entry;
    logic                                almost_full;

    // admission to packer
    beat_if beats ();

    ingress_admission #(
        .queue_beats (queue_beats)
    ) u_admission (
        .clk          (clk),
        .reset        (reset),
        .tvalid       (tvalid),
        .tdata        (tdata),
        .tkeep        (tkeep),
        .tlast        (tlast),
        .tuser        (tuser),
        .cal_done     (cal_done),
        .almost_full  (almost_full),
        .release_beat (release_beat),
        .tready       (tready),
        .beat_count   (beat_count),
        .beats        (beats.source)
    );

    beat_packer u_packer (
        .clk        (clk),
        .reset      (reset),
        .beats      (beats.sink),
        .push       (push),
        .push_entry (push_entry)
    );

    // almost_full loops back to throttle tready
    entry_fifo #(
        .fifo_depth         (fifo_depth),
        .almost_full_margin (almost_full_margin)
    ) u_fifo (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .push_entry  (push_entry),
        .rd          (rd),
        .entry       (entry),
        .empty       (empty),
        .almost_full (almost_full)
    );

endmodule

/* sources.f */
design/ingress_pkg.sv
design/beat_if.sv
design/ingress_admission.sv
design/beat_packer.sv
design/entry_fifo.sv
design/stream_ingress_top.sv
bench/ingress_checker.sv
bench/ingress_tb.sv
